// File: src/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 32;
    localparam int BE_WIDTH      = DATA_WIDTH / 8;
    localparam int REG_ADDR_BITS = 5;

    // 256 words, indexed by paddr[9:2]
    localparam int RAM_ADDR_BITS = 8;

    localparam int FIFO_DEPTH = 4;

    // 4 KiB pages
    localparam int PPN_WIDTH = 20;

    typedef enum logic [3:0] {
        LD_B,
        LD_BU,
        LD_H,
        LD_HU,
        LD_W,
        ST_B,
        ST_H,
        ST_W,
        LL_W,
        SC_W
    } mem_op_e;

endpackage

`default_nettype wire

// File: src/excp_pkg.sv
`default_nettype none

package excp_pkg;

    localparam int PLV_WIDTH = 2;

    localparam logic [PLV_WIDTH-1:0] PLV_KERNEL = 2'd0;
    localparam logic [PLV_WIDTH-1:0] PLV_USER   = 2'd3;

    // Highest priority first after NONE
    typedef enum logic [2:0] {
        NONE,
        ADEM,
        TLBR,
        PIL,
        PIS,
        PPI,
        PME
    } excp_code_e;

endpackage

`default_nettype wire

// File: src/mem1_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem1_stage
    import lsu_pkg::*;
    import excp_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     in_valid_i,
    output logic                          in_ready_o,
    input  wire mem_op_e                  in_op_i,
    input  wire logic [ADDR_WIDTH-1:0]    in_vaddr_i,
    input  wire logic [DATA_WIDTH-1:0]    in_wdata_i,
    input  wire logic [REG_ADDR_BITS-1:0] in_waddr_i,
    input  wire logic                     in_trans_en_i,

    input  wire logic                     tlb_found_i,
    input  wire logic                     tlb_v_i,
    input  wire logic                     tlb_d_i,
    input  wire logic [PLV_WIDTH-1:0]     tlb_plv_i,
    input  wire logic [PPN_WIDTH-1:0]     tlb_ppn_i,
    input  wire logic [PLV_WIDTH-1:0]     csr_plv_i,

    output logic                          push_o,
    output mem_op_e                       push_op_o,
    output logic [ADDR_WIDTH-1:0]         push_paddr_o,
    output logic [BE_WIDTH-1:0]           push_be_o,
    output logic [DATA_WIDTH-1:0]         push_data_o,
    output logic                          push_we_o,
    output logic [REG_ADDR_BITS-1:0]      push_waddr_o,
    output excp_code_e                    push_excp_o,
    output logic                          push_sc_ok_o,
    input  wire logic                     full_i
);

    logic                  is_load;
    logic                  is_store;
    logic                  access;
    logic                  accept;
    logic                  ll_bit;
    logic [ADDR_WIDTH-1:0] paddr;
    logic [1:0]            offs;
    excp_code_e            excp;

    // LL counts as a load, SC as a store
    assign is_load  = in_op_i inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL_W};
    assign is_store = in_op_i inside {ST_B, ST_H, ST_W, SC_W};
    assign access   = is_load | is_store;

    assign in_ready_o = !full_i;
    assign accept     = in_valid_i & in_ready_o;

    assign paddr = in_trans_en_i ? {tlb_ppn_i, in_vaddr_i[ADDR_WIDTH-PPN_WIDTH-1:0]}
                                 : in_vaddr_i;
    assign offs  = paddr[1:0];

    // First matching check wins
    always_comb begin
        excp = NONE;
        if (in_trans_en_i && access) begin
            if (csr_plv_i == PLV_USER && in_vaddr_i[ADDR_WIDTH-1])
                excp = ADEM;
            else if (!tlb_found_i)
                excp = TLBR;
            else if (!tlb_v_i)
                excp = is_load ? PIL : PIS;
            else if (csr_plv_i > tlb_plv_i)
                excp = PPI;
            else if (is_store && !tlb_d_i)
                excp = PME;
        end
    end

    // Byte lanes
    always_comb begin
        push_be_o   = '1;
        push_data_o = in_wdata_i;
        case (in_op_i)
            LD_B, LD_BU, ST_B: begin
                push_be_o   = BE_WIDTH'(1) << offs;
                push_data_o = in_wdata_i << {offs, 3'b000};
            end
            LD_H, LD_HU, ST_H: begin
                push_be_o   = BE_WIDTH'(3) << offs;
                push_data_o = in_wdata_i << {offs, 3'b000};
            end
            default: ;
        endcase
    end

    assign push_o       = accept;
    assign push_op_o    = in_op_i;
    assign push_paddr_o = paddr;
    assign push_waddr_o = in_waddr_i;
    assign push_excp_o  = excp;

    // A failed SC is pushed without a write
    assign push_we_o    = is_store && (in_op_i != SC_W || ll_bit);
    assign push_sc_ok_o = in_op_i == SC_W && ll_bit && excp == NONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            ll_bit <= 1'b0;
        end else if (accept && excp == NONE) begin
            if (in_op_i == LL_W)
                ll_bit <= 1'b1;
            else if (in_op_i == SC_W)
                ll_bit <= 1'b0;
        end
    end

    // Execute side holds a stalled instruction until it is accepted
    assert property (@(posedge clk) disable iff (rst)
        in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_op_i) && $stable(in_vaddr_i));

endmodule

`default_nettype wire

// File: src/mem_req_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module mem_req_fifo
    import lsu_pkg::*;
    import excp_pkg::*;
#(
    parameter int DEPTH = FIFO_DEPTH
) (
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     push_i,
    input  wire mem_op_e                  push_op_i,
    input  wire logic [ADDR_WIDTH-1:0]    push_paddr_i,
    input  wire logic [BE_WIDTH-1:0]      push_be_i,
    input  wire logic [DATA_WIDTH-1:0]    push_data_i,
    input  wire logic                     push_we_i,
    input  wire logic [REG_ADDR_BITS-1:0] push_waddr_i,
    input  wire excp_code_e               push_excp_i,
    input  wire logic                     push_sc_ok_i,
    output logic                          full_o,

    output logic                          req_o,
    output mem_op_e                       head_op_o,
    output logic [ADDR_WIDTH-1:0]         head_paddr_o,
    output logic [BE_WIDTH-1:0]           head_be_o,
    output logic [DATA_WIDTH-1:0]         head_data_o,
    output logic                          head_we_o,
    output logic [REG_ADDR_BITS-1:0]      head_waddr_o,
    output excp_code_e                    head_excp_o,
    output logic                          head_sc_ok_o,
    input  wire logic                     ack_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    mem_op_e                  op_q    [DEPTH];
    logic [ADDR_WIDTH-1:0]    paddr_q [DEPTH];
    logic [BE_WIDTH-1:0]      be_q    [DEPTH];
    logic [DATA_WIDTH-1:0]    data_q  [DEPTH];
    logic                     we_q    [DEPTH];
    logic [REG_ADDR_BITS-1:0] waddr_q [DEPTH];
    excp_code_e               excp_q  [DEPTH];
    logic                     sc_ok_q [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Pop on the first cycle ack is seen
    assign pop    = req_o & ack_i;
    assign full_o = count == (PTR_W+1)'(DEPTH);

    always_ff @(posedge clk) begin
        if (push_i) begin
            op_q[wr_ptr]    <= push_op_i;
            paddr_q[wr_ptr] <= push_paddr_i;
            be_q[wr_ptr]    <= push_be_i;
            data_q[wr_ptr]  <= push_data_i;
            we_q[wr_ptr]    <= push_we_i;
            waddr_q[wr_ptr] <= push_waddr_i;
            excp_q[wr_ptr]  <= push_excp_i;
            sc_ok_q[wr_ptr] <= push_sc_ok_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            req_o  <= 1'b0;
        end else begin
            if (push_i)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            count <= count + (PTR_W+1)'(push_i) - (PTR_W+1)'(pop);
            // New req only once the previous ack has gone low
            if (pop)
                req_o <= 1'b0;
            else if (!req_o && !ack_i && count != '0)
                req_o <= 1'b1;
        end
    end

    assign head_op_o    = op_q[rd_ptr];
    assign head_paddr_o = paddr_q[rd_ptr];
    assign head_be_o    = be_q[rd_ptr];
    assign head_data_o  = data_q[rd_ptr];
    assign head_we_o    = we_q[rd_ptr];
    assign head_waddr_o = waddr_q[rd_ptr];
    assign head_excp_o  = excp_q[rd_ptr];
    assign head_sc_ok_o = sc_ok_q[rd_ptr];

    assert property (@(posedge clk) disable iff (rst) count <= (PTR_W+1)'(DEPTH));

    assert property (@(posedge clk) disable iff (rst)
        req_o |=> !req_o || $stable({head_op_o, head_paddr_o, head_be_o, head_data_o,
                                     head_we_o, head_waddr_o, head_excp_o, head_sc_ok_o}));

endmodule

`default_nettype wire

// File: src/dcache_unit.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_unit
    import lsu_pkg::*;
    import excp_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     req_i,
    input  wire mem_op_e                  head_op_i,
    input  wire logic [ADDR_WIDTH-1:0]    head_paddr_i,
    input  wire logic [BE_WIDTH-1:0]      head_be_i,
    input  wire logic [DATA_WIDTH-1:0]    head_data_i,
    input  wire logic                     head_we_i,
    input  wire logic [REG_ADDR_BITS-1:0] head_waddr_i,
    input  wire excp_code_e               head_excp_i,
    input  wire logic                     head_sc_ok_i,
    output logic                          ack_o,

    output logic                          wb_valid_o,
    output logic [REG_ADDR_BITS-1:0]      wb_waddr_o,
    output logic [DATA_WIDTH-1:0]         wb_wdata_o,
    output excp_code_e                    wb_excp_o
);

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        RESP,
        WAIT_LOW
    } state_e;

    state_e                   state;
    logic [DATA_WIDTH-1:0]    ram [2**RAM_ADDR_BITS];
    logic [RAM_ADDR_BITS-1:0] idx;
    logic [DATA_WIDTH-1:0]    rd_q;
    logic [DATA_WIDTH-1:0]    lane;
    logic [DATA_WIDTH-1:0]    result;
    logic                     store_en;

    assign idx      = head_paddr_i[RAM_ADDR_BITS+1:2];
    assign store_en = head_we_i && head_excp_i == NONE;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (req_i) state <= ACCESS;
                ACCESS:   state <= RESP;
                RESP:     state <= WAIT_LOW;
                WAIT_LOW: if (!req_i) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // The read returns the word as it was before any store to it
    always_ff @(posedge clk) begin
        if (state == IDLE && req_i) begin
            rd_q <= ram[idx];
            for (int b = 0; b < BE_WIDTH; b++) begin
                if (store_en && head_be_i[b])
                    ram[idx][8*b +: 8] <= head_data_i[8*b +: 8];
            end
        end
    end

    assign lane = rd_q >> {head_paddr_i[1:0], 3'b000};

    always_comb begin
        case (head_op_i)
            LD_B:       result = {{(DATA_WIDTH-8){lane[7]}}, lane[7:0]};
            LD_BU:      result = {{(DATA_WIDTH-8){1'b0}}, lane[7:0]};
            LD_H:       result = {{(DATA_WIDTH-16){lane[15]}}, lane[15:0]};
            LD_HU:      result = {{(DATA_WIDTH-16){1'b0}}, lane[15:0]};
            LD_W, LL_W: result = rd_q;
            SC_W:       result = DATA_WIDTH'(head_sc_ok_i);
            default:    result = '0;
        endcase
    end

    // The queue still holds the head while the result registers
    always_ff @(posedge clk) begin
        if (state == ACCESS) begin
            wb_wdata_o <= (head_excp_i == NONE) ? result : '0;
            wb_waddr_o <= (head_op_i inside {ST_B, ST_H, ST_W}) ? '0 : head_waddr_i;
            wb_excp_o  <= head_excp_i;
        end
    end

    assign ack_o      = state == RESP || state == WAIT_LOW;
    assign wb_valid_o = state == RESP;

    assert property (@(posedge clk) disable iff (rst) $rose(ack_o) |-> req_i);

endmodule

`default_nettype wire

// File: src/lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
    import excp_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     rst,

    input  wire logic                     in_valid_i,
    output logic                          in_ready_o,
    input  wire mem_op_e                  in_op_i,
    input  wire logic [ADDR_WIDTH-1:0]    in_vaddr_i,
    input  wire logic [DATA_WIDTH-1:0]    in_wdata_i,
    input  wire logic [REG_ADDR_BITS-1:0] in_waddr_i,
    input  wire logic                     in_trans_en_i,

    input  wire logic                     tlb_found_i,
    input  wire logic                     tlb_v_i,
    input  wire logic                     tlb_d_i,
    input  wire logic [PLV_WIDTH-1:0]     tlb_plv_i,
    input  wire logic [PPN_WIDTH-1:0]     tlb_ppn_i,
    input  wire logic [PLV_WIDTH-1:0]     csr_plv_i,

    output logic                          wb_valid_o,
    output logic [REG_ADDR_BITS-1:0]      wb_waddr_o,
    output logic [DATA_WIDTH-1:0]         wb_wdata_o,
    output excp_code_e                    wb_excp_o
);

    logic                     push;
    mem_op_e                  push_op;
    logic [ADDR_WIDTH-1:0]    push_paddr;
    logic [BE_WIDTH-1:0]      push_be;
    logic [DATA_WIDTH-1:0]    push_data;
    logic                     push_we;
    logic [REG_ADDR_BITS-1:0] push_waddr;
    excp_code_e               push_excp;
    logic                     push_sc_ok;
    logic                     full;

    logic                     req;
    logic                     ack;
    mem_op_e                  head_op;
    logic [ADDR_WIDTH-1:0]    head_paddr;
    logic [BE_WIDTH-1:0]      head_be;
    logic [DATA_WIDTH-1:0]    head_data;
    logic                     head_we;
    logic [REG_ADDR_BITS-1:0] head_waddr;
    excp_code_e               head_excp;
    logic                     head_sc_ok;

    mem1_stage mem1_stage_i (
        .clk           (clk),
        .rst           (rst),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .in_op_i       (in_op_i),
        .in_vaddr_i    (in_vaddr_i),
        .in_wdata_i    (in_wdata_i),
        .in_waddr_i    (in_waddr_i),
        .in_trans_en_i (in_trans_en_i),
        .tlb_found_i   (tlb_found_i),
        .tlb_v_i       (tlb_v_i),
        .tlb_d_i       (tlb_d_i),
        .tlb_plv_i     (tlb_plv_i),
        .tlb_ppn_i     (tlb_ppn_i),
        .csr_plv_i     (csr_plv_i),
        .push_o        (push),
        .push_op_o     (push_op),
        .push_paddr_o  (push_paddr),
        .push_be_o     (push_be),
        .push_data_o   (push_data),
        .push_we_o     (push_we),
        .push_waddr_o  (push_waddr),
        .push_excp_o   (push_excp),
        .push_sc_ok_o  (push_sc_ok),
        .full_i        (full)
    );

    mem_req_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) mem_req_fifo_i (
        .clk          (clk),
        .rst          (rst),
        .push_i       (push),
        .push_op_i    (push_op),
        .push_paddr_i (push_paddr),
        .push_be_i    (push_be),
        .push_data_i  (push_data),
        .push_we_i    (push_we),
        .push_waddr_i (push_waddr),
        .push_excp_i  (push_excp),
        .push_sc_ok_i (push_sc_ok),
        .full_o       (full),
        .req_o        (req),
        .head_op_o    (head_op),
        .head_paddr_o (head_paddr),
        .head_be_o    (head_be),
        .head_data_o  (head_data),
        .head_we_o    (head_we),
        .head_waddr_o (head_waddr),
        .head_excp_o  (head_excp),
        .head_sc_ok_o (head_sc_ok),
        .ack_i        (ack)
    );

    dcache_unit dcache_unit_i (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req),
        .head_op_i    (head_op),
        .head_paddr_i (head_paddr),
        .head_be_i    (head_be),
        .head_data_i  (head_data),
        .head_we_i    (head_we),
        .head_waddr_i (head_waddr),
        .head_excp_i  (head_excp),
        .head_sc_ok_i (head_sc_ok),
        .ack_o        (ack),
        .wb_valid_o   (wb_valid_o),
        .wb_waddr_o   (wb_waddr_o),
        .wb_wdata_o   (wb_wdata_o),
        .wb_excp_o    (wb_excp_o)
    );

endmodule

`default_nettype wire

// File: dv/lsu_tb_ref.svh
`ifndef LSU_TB_REF_SVH
`define LSU_TB_REF_SVH

logic [DATA_WIDTH-1:0] shadow_mem [2**RAM_ADDR_BITS];
logic                  ref_ll;

function automatic excp_code_e ref_excp(input mem_op_e op, input logic [31:0] va,
                                        input logic trans, input logic found,
                                        input logic v, input logic d,
                                        input logic [1:0] tplv, input logic [1:0] cplv);
    logic ld;
    logic st;
    ld = op inside {LD_B, LD_BU, LD_H, LD_HU, LD_W, LL_W};
    st = op inside {ST_B, ST_H, ST_W, SC_W};
    if (!trans || !(ld || st))
        return NONE;
    if (cplv == PLV_USER && va[31])
        return ADEM;
    if (!found)
        return TLBR;
    if (ld && !v)
        return PIL;
    if (st && !v)
        return PIS;
    if (cplv > tplv)
        return PPI;
    if (st && !d)
        return PME;
    return NONE;
endfunction

// Returns {excp, waddr, wdata} and updates the shadow state
function automatic logic [39:0] ref_apply(input mem_op_e op, input logic [31:0] va,
                                          input logic [31:0] wd, input logic [4:0] wa,
                                          input excp_code_e e);
    logic [7:0]  idx;
    int          sh;
    logic [31:0] word;
    logic [31:0] rd;
    logic [31:0] data;
    logic [4:0]  waddr;
    idx   = va[9:2];
    sh    = 8 * int'(va[1:0]);
    word  = shadow_mem[idx];
    rd    = word >> sh;
    data  = '0;
    waddr = wa;
    case (op)
        LD_B:  data = {{24{rd[7]}}, rd[7:0]};
        LD_BU: data = {24'd0, rd[7:0]};
        LD_H:  data = {{16{rd[15]}}, rd[15:0]};
        LD_HU: data = {16'd0, rd[15:0]};
        LD_W:  data = word;
        LL_W: begin
            data = word;
            if (e == NONE)
                ref_ll = 1'b1;
        end
        ST_B, ST_H, ST_W: begin
            waddr = '0;
            if (e == NONE) begin
                if (op == ST_B)
                    word[sh +: 8] = wd[7:0];
                else if (op == ST_H)
                    word[sh +: 16] = wd[15:0];
                else
                    word = wd;
                shadow_mem[idx] = word;
            end
        end
        SC_W: begin
            if (e == NONE && ref_ll) begin
                shadow_mem[idx] = wd;
                data   = 32'd1;
                ref_ll = 1'b0;
            end
        end
        default: ;
    endcase
    if (e != NONE)
        data = '0;
    return {e, waddr, data};
endfunction

`endif

// File: dv/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
    import excp_pkg::*;
;
    localparam int NUM_RANDOM = 60;
    localparam int NUM_INSTR  = 16 + 31 + NUM_RANDOM;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic in_valid_i = 1'b0, in_trans_en_i = 1'b0;
    logic tlb_found_i = 1'b0, tlb_v_i = 1'b0, tlb_d_i = 1'b0;
    mem_op_e in_op_i = LD_W;
    logic [31:0] in_vaddr_i = '0, in_wdata_i = '0;
    logic [4:0]  in_waddr_i = '0;
    logic [1:0]  tlb_plv_i = '0, csr_plv_i = '0;
    logic [19:0] tlb_ppn_i = '0;
    logic        in_ready_o, wb_valid_o;
    logic [4:0]  wb_waddr_o;
    logic [31:0] wb_wdata_o;
    excp_code_e  wb_excp_o;

    logic [39:0] exp_q[$];
    logic [39:0] exp_head = '0;
    int          pending = 0;
    int          errors = 0;
    int          checks = 0;
    logic        saw_full = 1'b0;
    string       test_name = "reset";

    `include "lsu_tb_ref.svh"

    lsu_top lsu_top_i (.*);

    always #5 clk = ~clk;

    // One expected writeback per accepted instruction
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            ref_ll = 1'b0;
        end else begin
            if (wb_valid_o && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                checks++;
            end
            if (in_valid_i && in_ready_o)
                exp_q.push_back(ref_apply(in_op_i, in_vaddr_i, in_wdata_i, in_waddr_i,
                    ref_excp(in_op_i, in_vaddr_i, in_trans_en_i, tlb_found_i, tlb_v_i,
                             tlb_d_i, tlb_plv_i, csr_plv_i)));
            if (!in_ready_o)
                saw_full = 1'b1;
        end
        pending  = exp_q.size();
        exp_head = (exp_q.size() > 0) ? exp_q[0] : '0;
    end

    assert property (@(posedge clk) $fell(rst) |-> in_ready_o)
        else begin
            errors++;
            $display("in_ready_o low right after reset");
        end
    assert property (@(posedge clk) disable iff (rst) wb_valid_o |-> pending != 0)
        else begin
            errors++;
            $display("writeback with no instruction outstanding");
        end
    assert property (@(posedge clk) disable iff (rst) in_ready_o == (pending < FIFO_DEPTH))
        else begin
            errors++;
            $display("in_ready_o does not follow queue occupancy");
        end
    assert property (@(posedge clk) disable iff (rst)
        wb_valid_o && pending != 0 |-> wb_wdata_o == exp_head[31:0])
        else begin
            errors++;
            $display("** Error %s: wdata expected %h actual %h", test_name,
                     $sampled(exp_head[31:0]), $sampled(wb_wdata_o));
        end
    assert property (@(posedge clk) disable iff (rst)
        wb_valid_o && pending != 0 |-> wb_waddr_o == exp_head[36:32])
        else begin
            errors++;
            $display("** Error %s: waddr expected %h actual %h", test_name,
                     $sampled(exp_head[36:32]), $sampled(wb_waddr_o));
        end
    assert property (@(posedge clk) disable iff (rst)
        wb_valid_o && pending != 0 |-> wb_excp_o == excp_code_e'(exp_head[39:37]))
        else begin
            errors++;
            $display("** Error %s: excp expected %h actual %h", test_name,
                     $sampled(exp_head[39:37]), $sampled(wb_excp_o));
        end

    initial begin
        repeat (200 * NUM_INSTR) @(posedge clk);
        $display("Watchdog expired with %0d writebacks outstanding", pending);
        $display("sim failed");
        $finish;
    end

    task automatic set_tlb(input logic trans, input logic found, input logic v,
                           input logic d, input logic [1:0] tplv, input logic [1:0] cplv);
        in_trans_en_i = trans;
        tlb_found_i   = found;
        tlb_v_i       = v;
        tlb_d_i       = d;
        tlb_plv_i     = tplv;
        csr_plv_i     = cplv;
        tlb_ppn_i     = 20'($urandom);
    endtask

    // Holds valid until accepted and returns 1 ns after that edge
    task automatic issue(input mem_op_e op, input logic [31:0] va, input logic [31:0] wd);
        in_valid_i = 1'b1;
        in_op_i    = op;
        in_vaddr_i = va;
        in_wdata_i = wd;
        in_waddr_i = 5'($urandom_range(1, 31));
        do @(posedge clk); while (!in_ready_o);
        #1;
        in_valid_i = 1'b0;
    endtask

    // Waits until every issued instruction has written back
    task automatic drain();
        while (pending != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        mem_op_e op;
        logic [1:0] off;
        void'($urandom(32'hcd29));
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        repeat (3) @(posedge clk);
        #1;

        test_name = "init";
        for (int i = 0; i < 16; i++)
            issue(ST_W, 32'(i) << 2, ~{4{8'(i)}} ^ 32'h1357_9bdf);

        drain();
        test_name = "lanes";
        issue(ST_W, 32'h4, 32'h8899_aa7b);
        for (int b = 0; b < 4; b++) begin
            issue(LD_B, 32'h4 + b, 0);
            issue(LD_BU, 32'h4 + b, 0);
        end
        issue(LD_H, 32'h4, 0);
        issue(LD_HU, 32'h6, 0);
        issue(LD_H, 32'h6, 0);
        for (int b = 0; b < 4; b++)
            issue(ST_B, 32'h8 + b, 32'hc0 + b);
        issue(ST_H, 32'hc, 32'hbeef);
        issue(ST_H, 32'he, 32'h7e57);
        issue(LD_W, 32'h8, 0);
        issue(LD_W, 32'hc, 0);

        drain();
        test_name = "exceptions";
        set_tlb(1, 0, 0, 0, 0, PLV_USER);
        issue(LD_W, 32'h8000_0010, 0);
        set_tlb(1, 0, 1, 1, 0, PLV_KERNEL);
        issue(LD_W, 32'h10, 0);
        set_tlb(1, 1, 0, 0, 0, PLV_USER);
        issue(LD_H, 32'h12, 0);
        issue(ST_W, 32'h10, 32'hdead_0001);
        set_tlb(1, 1, 1, 0, PLV_KERNEL, PLV_USER);
        issue(ST_W, 32'h10, 32'hdead_0002);
        set_tlb(1, 1, 1, 0, PLV_USER, PLV_USER);
        issue(ST_B, 32'h11, 32'h55);
        set_tlb(0, 0, 0, 0, 0, PLV_KERNEL);
        issue(LD_W, 32'h10, 0);

        drain();
        test_name = "llsc";
        issue(LL_W, 32'h14, 0);
        issue(SC_W, 32'h14, 32'h5c5c_0001);
        issue(SC_W, 32'h14, 32'h5c5c_0002);
        issue(LD_W, 32'h14, 0);

        drain();
        test_name = "random";
        for (int i = 0; i < NUM_RANDOM; i++) begin
            op  = mem_op_e'($urandom_range(0, 9));
            off = 2'($urandom);
            if (op inside {LD_H, LD_HU, ST_H})
                off[0] = 1'b0;
            else if (!(op inside {LD_B, LD_BU, ST_B}))
                off = 2'b00;
            set_tlb(($urandom_range(0, 3) == 0), ($urandom_range(0, 5) != 0),
                    ($urandom_range(0, 5) != 0), ($urandom_range(0, 3) != 0),
                    2'($urandom), 2'($urandom));
            issue(op, {22'($urandom), 4'b0000, 4'($urandom), off}, $urandom);
        end
        set_tlb(0, 0, 0, 0, 0, PLV_KERNEL);

        drain();
        repeat (4) @(posedge clk);
        if (!saw_full) begin
            errors++;
            $display("Request queue never filled during the random run");
        end
        $display("Checked %0d writebacks, %0d errors", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+dv
src/lsu_pkg.sv
src/excp_pkg.sv
src/mem1_stage.sv
src/mem_req_fifo.sv
src/dcache_unit.sv
src/lsu_top.sv
dv/lsu_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= lsu_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass message"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
